//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_ghash
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/ghash_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// GHASH control FSM
// Accepts commands, sequences init, block absorption and tag generation,
// handles the clear command and locks up in a terminal error state
////////////////////////////////////////////////////////////////////////////

module ghash_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  input  ghash_pkg::ghash_cmd_t  cmd_i,
  input  logic                   alert_fatal_i,
  output logic                   alert_o,
  output logic                   first_block_o,
  input  logic                   mult_ack_i,
  output ghash_pkg::ghash_ctrl_t ctrl_o
);
  import ghash_pkg::*;

  ghash_fsm_e    state_q;
  ghash_fsm_e    state_d;
  gcm_phase_e    phase_q;
  gcm_phase_e    phase_d;
  logic          first_block_q;
  logic          first_block_d;
  logic          phase_legal;
  ghash_in_sel_e data_sel;

  assign phase_legal = cmd_i.phase inside {GCM_INIT, GCM_AAD, GCM_TEXT, GCM_TAG};

  // Only encryption hashes the cipher output and everything else the prior input
  assign data_sel = (cmd_i.phase == GCM_TEXT && cmd_i.op == GCM_ENC) ? IN_DATA_OUT
                                                                     : IN_DATA_PREV;

  always_comb begin : fsm
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    alert_o     = 1'b0;

    ctrl_o.in_sel         = IN_DATA_PREV;
    ctrl_o.state_sel      = STATE_ADD;
    ctrl_o.state_we       = 1'b0;
    ctrl_o.s_we           = 1'b0;
    ctrl_o.hash_subkey_we = 1'b0;
    ctrl_o.mult_req       = 1'b0;

    state_d       = state_q;
    phase_d       = phase_q;
    first_block_d = first_block_q;

    unique case (state_q)
      GHASH_IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          if (!phase_legal) begin
            state_d = GHASH_ERROR;
          end else if (cmd_i.clear) begin
            // Overwrite every register with the pseudo-random cipher output
            ctrl_o.s_we           = 1'b1;
            ctrl_o.hash_subkey_we = 1'b1;
            ctrl_o.state_sel      = STATE_INIT;
            ctrl_o.state_we       = 1'b1;
            first_block_d         = 1'b1;
            phase_d               = cmd_i.phase;
          end else if (cmd_i.phase == GCM_INIT) begin
            phase_d = GCM_INIT;
            if (cmd_i.load_hash_subkey) begin
              ctrl_o.hash_subkey_we = 1'b1;
            end else begin
              // Take S and seed the state with it so that ADD_S zeroes the state
              ctrl_o.s_we      = 1'b1;
              ctrl_o.state_sel = STATE_INIT;
              ctrl_o.state_we  = 1'b1;
              first_block_d    = 1'b1;
              state_d          = GHASH_ADD_S;
            end
          end else begin
            // AAD, TEXT and TAG all fold the block in before the multiply
            ctrl_o.in_sel   = data_sel;
            ctrl_o.state_we = 1'b1;
            phase_d         = cmd_i.phase;
            state_d         = GHASH_MULT;
          end
        end
      end

      GHASH_MULT: begin
        ctrl_o.mult_req = 1'b1;
        if (mult_ack_i) begin
          ctrl_o.state_sel = STATE_MULT;
          ctrl_o.state_we  = 1'b1;
          first_block_d    = 1'b0;
          state_d          = (phase_q == GCM_TAG) ? GHASH_ADD_S : GHASH_IDLE;
        end
      end

      GHASH_ADD_S: begin
        // Removes S after init, or adds it to form the tag
        ctrl_o.in_sel   = IN_S;
        ctrl_o.state_we = 1'b1;
        state_d         = (phase_q == GCM_INIT) ? GHASH_IDLE : GHASH_OUT;
      end

      GHASH_OUT: begin
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = GHASH_IDLE;
        end
      end

      GHASH_ERROR: begin
        alert_o = 1'b1;
      end

      default: begin
        alert_o = 1'b1;
        state_d = GHASH_ERROR;
      end
    endcase

    // A fatal alert overrides whatever step is in progress
    if (alert_fatal_i) begin
      state_d = GHASH_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_reg
    if (!rst_ni) begin
      state_q       <= GHASH_IDLE;
      phase_q       <= GCM_INIT;
      first_block_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      phase_q       <= phase_d;
      first_block_q <= first_block_d;
    end
  end

  assign first_block_o = first_block_q;

  // A command that waits for in_ready_o must be held stable by the sender
  cmd_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_i && !in_ready_o |=> !in_valid_i || $stable(cmd_i));

endmodule

//--- hdl/ghash_datapath.sv
////////////////////////////////////////////////////////////////////////////
// GHASH datapath
// Holds S, the hash subkey H and the GHASH state. The state is loaded from
// the cipher input, accumulates masked blocks and is multiplied by H
////////////////////////////////////////////////////////////////////////////

module ghash_datapath (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ghash_pkg::ghash_ctrl_t ctrl_i,
  input  ghash_pkg::gcm_block_t  hash_in_i,
  input  ghash_pkg::gcm_block_t  cipher_state_i,
  output ghash_pkg::gcm_block_t  s_o,
  output logic                   mult_ack_o,
  output ghash_pkg::gcm_block_t  ghash_state_o
);
  import ghash_pkg::*;

  gcm_block_t s_q;
  gcm_block_t hash_subkey_q;
  gcm_block_t state_q;
  gcm_block_t state_d;
  gcm_block_t state_add;
  gcm_block_t state_mult;

  ////////////////////////////////////////////////////////////////////////////
  // S and hash subkey
  ////////////////////////////////////////////////////////////////////////////

  // Both come straight from the cipher core, a clear loads them with
  // whatever pseudo-random block the cipher core presents
  always_ff @(posedge clk_i) begin : s_reg
    if (ctrl_i.s_we) begin
      s_q <= cipher_state_i;
    end
  end

  always_ff @(posedge clk_i) begin : hash_subkey_reg
    if (ctrl_i.hash_subkey_we) begin
      hash_subkey_q <= cipher_state_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // GHASH state
  ////////////////////////////////////////////////////////////////////////////

  // Addition in GF(2^128) is a plain XOR
  assign state_add = state_q ^ hash_in_i;

  // The state starts out as S and S is removed again by a later add,
  // which spares a dedicated zero input on this mux
  always_comb begin : state_mux
    unique case (ctrl_i.state_sel)
      STATE_INIT: state_d = cipher_state_i;
      STATE_ADD:  state_d = state_add;
      STATE_MULT: state_d = state_mult;
      default:    state_d = state_add;
    endcase
  end

  always_ff @(posedge clk_i) begin : state_reg
    if (ctrl_i.state_we) begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////////////////////

  // The state is the scanned operand, H stays put for the whole product
  ghash_gf_mult u_gf_mult (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ctrl_i.mult_req),
    .operand_a_i(state_q),
    .operand_b_i(hash_subkey_q),
    .ack_o      (mult_ack_o),
    .prod_o     (state_mult)
  );

  assign s_o           = s_q;
  assign ghash_state_o = state_q;

  // The product may only be selected once the multiplier has delivered it
  mult_sel_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_i.state_sel == STATE_MULT |-> mult_ack_o);

  // Operands of a running multiplication must not move under the scan
  mult_operands_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_i.mult_req && !mult_ack_o |=> $stable(state_q) && $stable(hash_subkey_q));

endmodule

//--- hdl/ghash_gf_mult.sv
////////////////////////////////////////////////////////////////////////////
// GF(2^128) multiplier
// Digit-serial multiplier that scans operand A one digit per cycle and
// reduces by the GCM polynomial. Operands and product use GCM bit order
////////////////////////////////////////////////////////////////////////////

module ghash_gf_mult (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  ghash_pkg::gcm_block_t operand_a_i,
  input  ghash_pkg::gcm_block_t operand_b_i,
  output logic                  ack_o,
  output ghash_pkg::gcm_block_t prod_o
);
  import ghash_pkg::*;

  gcm_block_t              a_rev;
  gcm_block_t              b_rev;
  gcm_block_t              acc_q;
  gcm_block_t              acc_d;
  logic [GfDigitWidth-1:0] digit;
  gf_cnt_t                 cnt_q;
  logic                    last;

  // GCM stores the x^0 coefficient in bit 127 and the multiplier wants it in bit 0
  function automatic gcm_block_t reflect(gcm_block_t in);
    gcm_block_t out;
    for (int i = 0; i < GcmDegree; i++) begin
      out[i] = in[GcmDegree-1-i];
    end
    return out;
  endfunction

  assign a_rev = reflect(operand_a_i);
  assign b_rev = reflect(operand_b_i);

  // Digits of A are taken from the most significant end first
  assign digit = a_rev[GcmDegree - 1 - GfDigitWidth * int'(cnt_q) -: GfDigitWidth];
  assign last  = (cnt_q == gf_cnt_t'(GfMultCycles - 1));

  // Each Horner step shifts and reduces, then adds B where the digit bit is set
  always_comb begin : digit_step
    acc_d = acc_q;
    for (int j = GfDigitWidth - 1; j >= 0; j--) begin
      acc_d = {acc_d[GcmDegree-2:0], 1'b0} ^ (acc_d[GcmDegree-1] ? GcmIPoly : '0);
      if (digit[j]) begin
        acc_d = acc_d ^ b_rev;
      end
    end
  end

  // The counter restarts whenever the request is low or a product is done
  always_ff @(posedge clk_i or negedge rst_ni) begin : cnt_reg
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!req_i || last) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // The partial product is cleared between requests
  always_ff @(posedge clk_i) begin : acc_reg
    if (!req_i || last) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_d;
    end
  end

  // The last digit is folded in combinationally during the acknowledge cycle
  assign ack_o  = req_i & last;
  assign prod_o = reflect(acc_d);

  // Every request asks for one product, so the requester drops it after ack
  req_drop_after_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |=> !req_i);

endmodule

//--- hdl/ghash_input_sel.sv
////////////////////////////////////////////////////////////////////////////
// GHASH input selection
// Picks the block to hash and zeroes the bytes beyond the valid count
////////////////////////////////////////////////////////////////////////////

module ghash_input_sel (
  input  ghash_pkg::ghash_in_sel_e in_sel_i,
  input  ghash_pkg::gcm_block_t    data_in_prev_i,
  input  ghash_pkg::gcm_block_t    data_out_i,
  input  ghash_pkg::gcm_block_t    s_i,
  input  ghash_pkg::nvb_t          num_valid_bytes_i,
  output ghash_pkg::gcm_block_t    hash_in_o
);
  import ghash_pkg::*;

  gcm_block_t sel_block;
  gcm_block_t byte_mask;

  // AAD and decryption hash the previous input, encryption the cipher output
  always_comb begin : in_mux
    unique case (in_sel_i)
      IN_DATA_PREV: sel_block = data_in_prev_i;
      IN_DATA_OUT:  sel_block = data_out_i;
      IN_S:         sel_block = s_i;
      default:      sel_block = data_out_i;
    endcase
  end

  // Byte 0 sits in bits 127 down to 120, so the mask grows from the top
  always_comb begin : mask_gen
    for (int i = 0; i < NumBlockBytes; i++) begin
      byte_mask[GcmDegree-1-8*i -: 8] = (nvb_t'(i) < num_valid_bytes_i) ? 8'hff : 8'h00;
    end
  end

  // S is always a whole block
  assign hash_in_o = (in_sel_i == IN_S) ? sel_block : (sel_block & byte_mask);

  // A count above one block would leave the mask undefined in meaning
  always_comb begin : nvb_check
    nvb_range_a: assert final (in_sel_i == IN_S ||
                               num_valid_bytes_i <= nvb_t'(NumBlockBytes));
  end

endmodule

//--- hdl/ghash_pkg.sv
////////////////////////////////////////////////////////////////////////////
// GHASH package
// Widths, command and control types, FSM encodings and the constants of
// the digit-serial GF(2^128) multiplier used by the GHASH engine
////////////////////////////////////////////////////////////////////////////

package ghash_pkg;

  // A block is a bit string in GCM order, so bit 127 is the first bit
  localparam int unsigned GcmDegree = 128;
  typedef logic [GcmDegree-1:0] gcm_block_t;

  localparam int unsigned NumBlockBytes = GcmDegree / 8;
  // Count of valid bytes in a block, 0 up to 16
  typedef logic [4:0] nvb_t;

  // The multiplier consumes one digit of operand A per cycle
  localparam int unsigned GfMultCycles = 8;
  localparam int unsigned GfDigitWidth = GcmDegree / GfMultCycles;
  typedef logic [$clog2(GfMultCycles)-1:0] gf_cnt_t;

  // Reduction constant of x^128 + x^7 + x^2 + x + 1 in MSB-first order
  localparam gcm_block_t GcmIPoly = {120'h0, 8'h87};

  // Three bits so that stray encodings can be caught as illegal
  typedef enum logic [2:0] {
    GCM_INIT = 3'b001,
    GCM_AAD  = 3'b010,
    GCM_TEXT = 3'b011,
    GCM_TAG  = 3'b100
  } gcm_phase_e;

  typedef enum logic {
    GCM_ENC = 1'b0,
    GCM_DEC = 1'b1
  } gcm_op_e;

  typedef struct packed {
    gcm_phase_e phase;
    gcm_op_e    op;
    nvb_t       num_valid_bytes;
    logic       load_hash_subkey;
    logic       clear;
  } ghash_cmd_t;

  typedef enum logic [1:0] {
    IN_DATA_PREV,
    IN_DATA_OUT,
    IN_S
  } ghash_in_sel_e;

  typedef enum logic [1:0] {
    STATE_INIT,
    STATE_ADD,
    STATE_MULT
  } ghash_state_sel_e;

  typedef struct packed {
    ghash_in_sel_e    in_sel;
    ghash_state_sel_e state_sel;
    logic             state_we;
    logic             s_we;
    logic             hash_subkey_we;
    logic             mult_req;
  } ghash_ctrl_t;

  typedef enum logic [2:0] {
    GHASH_IDLE,
    GHASH_MULT,
    GHASH_ADD_S,
    GHASH_OUT,
    GHASH_ERROR
  } ghash_fsm_e;

endpackage

//--- hdl/ghash_top.sv
////////////////////////////////////////////////////////////////////////////
// GHASH engine top level
// Connects the control FSM, the input selection and the datapath
////////////////////////////////////////////////////////////////////////////

module ghash_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  ghash_pkg::ghash_cmd_t cmd_i,
  input  ghash_pkg::gcm_block_t data_in_prev_i,
  input  ghash_pkg::gcm_block_t data_out_i,
  input  ghash_pkg::gcm_block_t cipher_state_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output ghash_pkg::gcm_block_t ghash_state_o,
  output logic                  first_block_o,
  input  logic                  alert_fatal_i,
  output logic                  alert_o
);
  import ghash_pkg::*;

  ghash_ctrl_t ctrl;
  gcm_block_t  hash_in;
  gcm_block_t  s;
  logic        mult_ack;

  ghash_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .cmd_i        (cmd_i),
    .alert_fatal_i(alert_fatal_i),
    .alert_o      (alert_o),
    .first_block_o(first_block_o),
    .mult_ack_i   (mult_ack),
    .ctrl_o       (ctrl)
  );

  // Byte masking uses the count of the command being transferred
  ghash_input_sel u_input_sel (
    .in_sel_i         (ctrl.in_sel),
    .data_in_prev_i   (data_in_prev_i),
    .data_out_i       (data_out_i),
    .s_i              (s),
    .num_valid_bytes_i(cmd_i.num_valid_bytes),
    .hash_in_o        (hash_in)
  );

  ghash_datapath u_datapath (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl),
    .hash_in_i     (hash_in),
    .cipher_state_i(cipher_state_i),
    .s_o           (s),
    .mult_ack_o    (mult_ack),
    .ghash_state_o (ghash_state_o)
  );

endmodule

//--- project.f
+incdir+include
hdl/ghash_pkg.sv
hdl/ghash_gf_mult.sv
hdl/ghash_input_sel.sv
hdl/ghash_datapath.sv
hdl/ghash_ctrl.sv
hdl/ghash_top.sv
tb/tb_ghash.sv

//--- include/tb_ghash_model.svh
////////////////////////////////////////////////////////////////////////////
// GHASH reference model
// Bitwise GF(2^128) multiply, GHASH step, byte masking and the LFSR that
// supplies random stimulus to the testbench
////////////////////////////////////////////////////////////////////////////

`ifndef TB_GHASH_MODEL_SVH
`define TB_GHASH_MODEL_SVH

// Right-shift multiply from the GCM specification where bit 127 holds x^0
function automatic gcm_block_t gf_mult_ref(gcm_block_t x, gcm_block_t y);
  gcm_block_t z;
  gcm_block_t v;
  z = '0;
  v = y;
  for (int i = 0; i < GcmDegree; i++) begin
    if (x[GcmDegree-1-i]) begin
      z = z ^ v;
    end
    // Dividing by x folds the x^127 term back in through R = e1 || 0^120
    v = v[0] ? ((v >> 1) ^ {8'he1, 120'h0}) : (v >> 1);
  end
  return z;
endfunction

// Keeps the first nvb bytes of a block and zeroes all later ones
function automatic gcm_block_t mask_bytes(gcm_block_t blk, int unsigned nvb);
  gcm_block_t masked;
  masked = blk;
  for (int b = 0; b < NumBlockBytes; b++) begin
    if (b >= int'(nvb)) begin
      masked[GcmDegree-1-8*b -: 8] = 8'h00;
    end
  end
  return masked;
endfunction

// One GHASH iteration computes (Y xor masked X) times H
function automatic gcm_block_t ghash_step(gcm_block_t y, gcm_block_t x, gcm_block_t h,
                                          int unsigned nvb);
  return gf_mult_ref(y ^ mask_bytes(x, nvb), h);
endfunction

// Galois LFSR for x^32 + x^22 + x^2 + x + 1 shifting right
function automatic logic [31:0] lfsr_step(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

`endif

//--- tb/tb_ghash.sv
////////////////////////////////////////////////////////////////////////////
// GHASH engine testbench
// Directed tests of reset values, the GCM known answer, random messages,
// handshake timing, the clear command and the error state
////////////////////////////////////////////////////////////////////////////

module tb_ghash;
  timeunit 1ns;
  timeprecision 1ps;
  import ghash_pkg::*;

  `include "tb_ghash_model.svh"

  localparam int unsigned Timeout = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        in_valid;
  logic        in_ready;
  ghash_cmd_t  cmd;
  gcm_block_t  data_in_prev;
  gcm_block_t  data_out;
  gcm_block_t  cipher_state;
  logic        out_valid;
  logic        out_ready;
  gcm_block_t  ghash_state;
  logic        first_block;
  logic        alert_fatal;
  logic        alert;
  int unsigned errors;
  logic [31:0] lfsr_q;

  ghash_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (in_valid),
    .in_ready_o    (in_ready),
    .cmd_i         (cmd),
    .data_in_prev_i(data_in_prev),
    .data_out_i    (data_out),
    .cipher_state_i(cipher_state),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready),
    .ghash_state_o (ghash_state),
    .first_block_o (first_block),
    .alert_fatal_i (alert_fatal),
    .alert_o       (alert)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // All outputs are Moore, so 1 ns after the edge they are settled
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_run();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic timed_out(string what);
    errors++;
    $display("Timeout: %s did not go high within %0d cycles", what, Timeout);
    finish_run();
  endtask

  function automatic gcm_block_t rand_bits(int unsigned n);
    gcm_block_t r;
    r = '0;
    for (int i = 0; i < int'(n); i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[GcmDegree-2:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check_block(string name, gcm_block_t exp, gcm_block_t act);
    assert (act === exp) else begin
      errors++;
      $display("mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    assert (act === exp) else begin
      errors++;
      $display("mismatch in %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int unsigned exp, int unsigned act);
    assert (act == exp) else begin
      errors++;
      $display("mismatch in %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  function automatic ghash_cmd_t build_cmd(gcm_phase_e phase, gcm_op_e op, int unsigned nvb,
                                           logic load_h, logic clr);
    ghash_cmd_t c;
    c.phase            = phase;
    c.op               = op;
    c.num_valid_bytes  = nvb_t'(nvb);
    c.load_hash_subkey = load_h;
    c.clear            = clr;
    return c;
  endfunction

  // Latency counts from the transfer cycle, which is cycle 0
  task automatic wait_for(logic tag, output int unsigned lat);
    lat = 1;
    while (!(tag ? out_valid : in_ready)) begin
      if (lat > Timeout) begin
        if (tag) begin
          timed_out("out_valid_o");
        end else begin
          timed_out("in_ready_o");
        end
      end
      next_cycle();
      lat++;
    end
  endtask

  // One command transfer followed by the wait for ready, or for the tag
  task automatic run_cmd(ghash_cmd_t c, gcm_block_t prev, gcm_block_t dout, gcm_block_t cs,
                         output int unsigned lat);
    int unsigned idle;
    idle = 0;
    while (!in_ready) begin
      if (idle >= Timeout) begin
        timed_out("in_ready_o before a command");
      end
      next_cycle();
      idle++;
    end
    in_valid     = 1'b1;
    cmd          = c;
    data_in_prev = prev;
    data_out     = dout;
    cipher_state = cs;
    next_cycle();
    in_valid = 1'b0;
    wait_for(c.phase == GCM_TAG, lat);
  endtask

  task automatic load_subkey(gcm_block_t h);
    int unsigned lat;
    run_cmd(build_cmd(GCM_INIT, GCM_ENC, 16, 1'b1, 1'b0), '0, '0, h, lat);
    check_count("subkey load latency", 1, lat);
  endtask

  // INIT loads S and ADD_S cancels it, so the state must read zero
  task automatic start_message(gcm_block_t s);
    int unsigned lat;
    run_cmd(build_cmd(GCM_INIT, GCM_ENC, 16, 1'b0, 1'b0), '0, '0, s, lat);
    check_count("init latency", 2, lat);
    check_block("init state", '0, ghash_state);
    check_flag("init first_block_o", 1'b1, first_block);
  endtask

  // AAD and decryption hash data_in_prev, encryption hashes data_out
  task automatic hash_random_block(gcm_phase_e phase, gcm_op_e op, int unsigned nvb,
                                   gcm_block_t h, inout gcm_block_t y);
    gcm_block_t  prev;
    gcm_block_t  dout;
    int unsigned lat;
    prev = rand_bits(GcmDegree);
    dout = rand_bits(GcmDegree);
    run_cmd(build_cmd(phase, op, nvb, 1'b0, 1'b0), prev, dout, '0, lat);
    check_count("block latency", GfMultCycles + 1, lat);
    check_flag("first_block_o after a block", 1'b0, first_block);
    y = ghash_step(y, (phase == GCM_TEXT && op == GCM_ENC) ? dout : prev, h, nvb);
  endtask

  // Holds off out_ready_i for a while, then takes the tag
  task automatic take_tag(int unsigned stall, output gcm_block_t tag);
    tag = ghash_state;
    repeat (stall) begin
      next_cycle();
      check_flag("stalled out_valid_o", 1'b1, out_valid);
      check_block("stalled tag", tag, ghash_state);
    end
    out_ready = 1'b1;
    next_cycle();
    out_ready = 1'b0;
    check_flag("in_ready_o after the tag", 1'b1, in_ready);
  endtask

  task automatic check_tag(string name, gcm_block_t len, gcm_block_t h, gcm_block_t s,
                           gcm_block_t y, int unsigned stall);
    gcm_block_t  tag;
    int unsigned lat;
    run_cmd(build_cmd(GCM_TAG, GCM_ENC, 16, 1'b0, 1'b0), len, rand_bits(GcmDegree), '0, lat);
    check_count({name, " tag latency"}, GfMultCycles + 2, lat);
    take_tag(stall, tag);
    check_block({name, " tag"}, ghash_step(y, len, h, NumBlockBytes) ^ s, tag);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    check_flag("reset in_ready_o", 1'b1, in_ready);
    check_flag("reset out_valid_o", 1'b0, out_valid);
    check_flag("reset alert_o", 1'b0, alert);
    check_flag("reset first_block_o", 1'b0, first_block);
  endtask

  // Test case 2 of the GCM specification, one all-zero plaintext block
  task automatic known_answer();
    gcm_block_t  tag;
    int unsigned lat;
    load_subkey(128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
    start_message(128'h58e2fccefa7e3061367f1d57a4e7455a);
    run_cmd(build_cmd(GCM_TEXT, GCM_ENC, 16, 1'b0, 1'b0), rand_bits(GcmDegree),
            128'h0388dace60b6a392f328c2b971b2fe78, '0, lat);
    check_flag("known answer first_block_o", 1'b0, first_block);
    run_cmd(build_cmd(GCM_TAG, GCM_ENC, 16, 1'b0, 1'b0), 128'h80, '0, '0, lat);
    take_tag(0, tag);
    check_block("known answer tag", 128'hab6e47d42cec13bdf53a67b21257bddf, tag);
  endtask

  // The last block is partial and carries random garbage past its end
  task automatic random_messages();
    gcm_block_t  h;
    gcm_block_t  s;
    gcm_block_t  y;
    gcm_block_t  bits;
    gcm_op_e     op;
    int unsigned nvb;
    h = rand_bits(GcmDegree);
    s = rand_bits(GcmDegree);
    y = '0;
    nvb = 16;
    load_subkey(h);
    start_message(s);
    hash_random_block(GCM_AAD, GCM_ENC, 16, h, y);
    hash_random_block(GCM_AAD, GCM_DEC, 16, h, y);
    for (int i = 0; i < 3; i++) begin
      bits = rand_bits(5);
      op   = (bits[0] ^ i[0]) ? GCM_DEC : GCM_ENC;
      nvb  = (i == 2) ? 1 + int'(bits[4:1]) : 16;
      hash_random_block(GCM_TEXT, op, nvb, h, y);
    end
    check_tag("random message", {64'd256, 64'(256 + 8 * nvb)}, h, s, y, 0);
  endtask

  // Block and init latencies are checked inside the helpers as well
  task automatic handshake_timing();
    gcm_block_t h;
    gcm_block_t s;
    gcm_block_t y;
    gcm_block_t bits;
    h = rand_bits(GcmDegree);
    s = rand_bits(GcmDegree);
    y = '0;
    bits = rand_bits(3);
    load_subkey(h);
    start_message(s);
    hash_random_block(GCM_AAD, GCM_ENC, 16, h, y);
    check_tag("timing", {64'd128, 64'd0}, h, s, y, 2 + int'(bits[2:0]));
  endtask

  // After a clear H is the cleared value, so the next message uses it
  task automatic clear_command();
    gcm_block_t  c;
    gcm_block_t  s;
    gcm_block_t  y;
    int unsigned lat;
    c = rand_bits(GcmDegree);
    s = rand_bits(GcmDegree);
    y = '0;
    run_cmd(build_cmd(GCM_INIT, GCM_ENC, 16, 1'b0, 1'b1), '0, '0, c, lat);
    check_count("clear latency", 1, lat);
    check_block("clear state", c, ghash_state);
    check_flag("clear first_block_o", 1'b1, first_block);
    start_message(s);
    hash_random_block(GCM_AAD, GCM_ENC, 16, c, y);
    hash_random_block(GCM_TEXT, GCM_DEC, 16, c, y);
    check_tag("clear", {64'd128, 64'd128}, c, s, y, 0);
  endtask

  // ERROR is terminal, so a single alert pulse must lock the engine
  task automatic error_lockup();
    alert_fatal = 1'b1;
    next_cycle();
    alert_fatal = 1'b0;
    repeat (20) begin
      check_flag("error alert_o", 1'b1, alert);
      check_flag("error in_ready_o", 1'b0, in_ready);
      next_cycle();
    end
  endtask

  initial begin : main
    errors       = 0;
    lfsr_q       = 32'hd2ac4e1b;
    rst_ni       = 1'b0;
    in_valid     = 1'b0;
    cmd          = build_cmd(GCM_INIT, GCM_ENC, 0, 1'b0, 1'b0);
    data_in_prev = '0;
    data_out     = '0;
    cipher_state = '0;
    out_ready    = 1'b0;
    alert_fatal  = 1'b0;
    repeat (3) next_cycle();
    rst_ni = 1'b1;
    reset_values();
    known_answer();
    random_messages();
    handshake_timing();
    clear_command();
    error_lockup();
    finish_run();
  end

endmodule
